// File: bench/icmu_chk.sv
// Protocol assertions for the dispatcher and the grant queue that the testbench attaches by bind
`timescale 1ns/1ps
`include "icmu_defines.svh"

module icmu_chk import icmu_pkg::*; (
    input logic                       clk,
    input logic                       rst_n_buf,
    input svc_state_t                 state,
    input logic [`ICMU_INT_WIDTH-1:0] int_ack,
    input logic                       active,
    input logic                       pop,
    input logic                       empty,
    input logic                       overflow
);

    // One sticky bit per assertion
    bit ack_bad   = 1'b0;
    bit state_bad = 1'b0;
    bit pop_bad   = 1'b0;
    bit ovf_bad   = 1'b0;

    // Testbench polls this
    logic failed;
    assign failed = ack_bad | state_bad | pop_bad | ovf_bad;

    // At most one source acknowledged at a time
    ack_onehot: assert property (@(posedge clk) disable iff (!rst_n_buf) $onehot0(int_ack))
        else begin
            $error("int_ack has more than one bit set: %b", int_ack);
            ack_bad = 1'b1;
        end

    // Active rises only on the edge that pops a grant into SVC_ACTIVE
    active_state: assert property (@(posedge clk) disable iff (!rst_n_buf)
        $rose(active) |-> $past(pop) && (state == SVC_ACTIVE))
        else begin
            $error("active rose without a pop into the active state");
            state_bad = 1'b1;
        end

    // Pop only while the queue holds something
    pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n_buf) !(pop && empty))
        else begin
            $error("pop strobed while the queue is empty");
            pop_bad = 1'b1;
        end

    // Overflow is sticky until reset
    ovf_sticky: assert property (@(posedge clk) disable iff (!rst_n_buf) overflow |=> overflow)
        else begin
            $error("overflow fell without a reset");
            ovf_bad = 1'b1;
        end

endmodule

// File: bench/icmu_tb.sv
// Self-checking testbench for the interrupt controller, runs a request table against a mask model
`timescale 1ns/1ps
`include "icmu_defines.svh"

module icmu_tb;

    localparam int INT_W    = `ICMU_INT_WIDTH;
    localparam int CTX_W    = `ICMU_CTX_WIDTH;
    localparam int ID_W     = `ICMU_ID_WIDTH;
    localparam int DEPTH    = `ICMU_FIFO_DEPTH;
    localparam int NUM_ROWS = 15;
    localparam int WAIT_MAX = 10;
    localparam int HOLD_CYC = 3;

    // One table row, burst rows go out back to back
    // done clear means the handler withholds done for a few cycles
    typedef struct {
        string            name;
        logic [INT_W-1:0] req;
        logic [INT_W-1:0] clr;
        bit               burst;
        bit               done;
    } row_t;

    logic             clk;
    logic             rst_n_buf;
    logic [INT_W-1:0] int_req;
    logic [CTX_W-1:0] current_ctx;
    logic [INT_W-1:0] int_clear;
    logic             svc_done;
    logic [INT_W-1:0] int_ack;
    logic [ID_W-1:0]  int_id;
    logic [CTX_W-1:0] saved_ctx;
    logic             active;
    logic             overflow;

    row_t             rows [NUM_ROWS];
    logic [31:0]      lfsr;
    logic [INT_W-1:0] model_mask;
    logic             exp_ovf;
    logic [ID_W-1:0]  exp_ids [$];
    logic [CTX_W-1:0] exp_ctxs [$];

    icmu_top dut0 (
        .clk         (clk),
        .rst_n_buf   (rst_n_buf),
        .int_req     (int_req),
        .current_ctx (current_ctx),
        .int_clear   (int_clear),
        .svc_done    (svc_done),
        .int_ack     (int_ack),
        .int_id      (int_id),
        .saved_ctx   (saved_ctx),
        .active      (active),
        .overflow    (overflow)
    );

    // Dispatcher has no overflow view, tied low
    bind svc_dispatch icmu_chk chk_disp (
        .clk       (clk),
        .rst_n_buf (rst_n_buf),
        .state     (state),
        .int_ack   (int_ack),
        .active    (active),
        .pop       (d.pop),
        .empty     (d.empty),
        .overflow  (1'b0)
    );

    // Queue side has no FSM, state and ack tied idle
    bind grant_queue icmu_chk chk_queue (
        .clk       (clk),
        .rst_n_buf (rst_n_buf),
        .state     (icmu_pkg::SVC_IDLE),
        .int_ack   ({`ICMU_INT_WIDTH{1'b0}}),
        .active    (1'b0),
        .pop       (q.pop),
        .empty     (q.empty),
        .overflow  (q.overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Bound by the table length
    initial begin
        repeat (NUM_ROWS * 20 + 100) @(posedge clk);
        $display("Timeout: the table did not complete within the allowed cycles");
        abort_run();
    end

    // Any fired protocol assertion ends the run
    always @(negedge clk) begin
        assert (!(dut0.disp0.chk_disp.failed || dut0.queue0.chk_queue.failed))
            else begin
                $display("A protocol assertion in the bound checker fired");
                abort_run();
            end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("Mismatch %s %s expected %0h actual %0h", name, what, expected, actual);
        abort_run();
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per context bit
    task automatic next_ctx(output logic [CTX_W-1:0] value);
        value = '0;
        for (int i = 0; i < CTX_W; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[CTX_W-2:0], lfsr[0]};
        end
    endtask

    // Scan from the top, -1 when nothing is set
    function automatic int top_bit(input logic [INT_W-1:0] v);
        for (int i = INT_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic wait_for_active(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < WAIT_MAX) begin
            @(negedge clk);
            seen = active;
            n++;
        end
    endtask

    task automatic check_grant(input string name, input logic [ID_W-1:0] exp_id,
                               input logic [CTX_W-1:0] exp_ctx);
        logic [INT_W-1:0] exp_ack;
        exp_ack         = '0;
        exp_ack[exp_id] = 1'b1;
        assert (active) else report_mismatch(name, "active", 64'(1'b1), 64'(active));
        assert (int_id == exp_id) else report_mismatch(name, "int_id", 64'(exp_id), 64'(int_id));
        assert (int_ack == exp_ack)
            else report_mismatch(name, "int_ack", 64'(exp_ack), 64'(int_ack));
        assert (saved_ctx == exp_ctx)
            else report_mismatch(name, "saved_ctx", 64'(exp_ctx), 64'(saved_ctx));
    endtask

    // Wait for the grant, hold it, then strobe done for one cycle
    task automatic serve_grant(input string name, input logic [ID_W-1:0] exp_id,
                               input logic [CTX_W-1:0] exp_ctx, input int hold);
        bit seen;
        wait_for_active(seen);
        assert (seen) else report_mismatch(name, "active", 64'(1'b1), 64'(1'b0));
        check_grant(name, exp_id, exp_ctx);
        repeat (hold) begin
            @(negedge clk);
            check_grant(name, exp_id, exp_ctx);
        end
        @(posedge clk);
        svc_done <= 1'b1;
        @(posedge clk);
        svc_done <= 1'b0;
        @(negedge clk);
        assert (!active) else report_mismatch(name, "active after done", 64'(1'b0), 64'(active));
        assert (int_ack == '0)
            else report_mismatch(name, "int_ack after done", 64'(0), 64'(int_ack));
    endtask

    task automatic load_table();
        rows[0]  = '{"prio_multi",   8'hA6, 8'h00, 1'b0, 1'b1};
        rows[1]  = '{"prio_hold",    8'h06, 8'h00, 1'b0, 1'b0};
        rows[2]  = '{"mask_same",    8'h80, 8'h00, 1'b0, 1'b1};
        rows[3]  = '{"mask_lower",   8'h90, 8'h00, 1'b0, 1'b1};
        rows[4]  = '{"clear_7",      8'h00, 8'h80, 1'b0, 1'b1};
        rows[5]  = '{"regrant_7",    8'h80, 8'h00, 1'b0, 1'b0};
        rows[6]  = '{"clear_all",    8'h00, 8'hFF, 1'b0, 1'b1};
        rows[7]  = '{"burst_b1",     8'h02, 8'h00, 1'b1, 1'b0};
        rows[8]  = '{"burst_b5",     8'h20, 8'h00, 1'b1, 1'b0};
        rows[9]  = '{"burst_b0",     8'h01, 8'h00, 1'b1, 1'b0};
        rows[10] = '{"burst_b6",     8'h40, 8'h00, 1'b1, 1'b0};
        rows[11] = '{"burst_b3",     8'h08, 8'h00, 1'b1, 1'b0};
        rows[12] = '{"burst_b7",     8'h80, 8'h00, 1'b1, 1'b0};
        rows[13] = '{"after_burst",  8'h24, 8'h00, 1'b0, 1'b1};
        // Bit 7 was masked by its push even though the queue dropped it
        rows[14] = '{"dropped_mask", 8'h80, 8'h00, 1'b0, 1'b1};
    endtask

    initial begin
        logic [CTX_W-1:0] ctx;
        logic [INT_W-1:0] eff;
        logic [ID_W-1:0]  id;
        bit               last;
        bit               seen;
        rst_n_buf   = 1'b0;
        int_req     = '0;
        current_ctx = '0;
        int_clear   = '0;
        svc_done    = 1'b0;
        lfsr        = 32'h57dea00c;
        model_mask  = '0;
        exp_ovf     = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        rst_n_buf <= 1'b1;
        @(negedge clk);
        assert (!active) else report_mismatch("reset", "active", 64'(1'b0), 64'(active));
        assert (int_ack == '0) else report_mismatch("reset", "int_ack", 64'(0), 64'(int_ack));
        assert (!overflow) else report_mismatch("reset", "overflow", 64'(1'b0), 64'(overflow));
        for (int r = 0; r < NUM_ROWS; r++) begin
            next_ctx(ctx);
            // Clear lands before the masking stage reads the mask
            model_mask = model_mask & ~rows[r].clr;
            eff        = rows[r].req & ~model_mask;
            @(posedge clk);
            int_req     <= rows[r].req;
            int_clear   <= rows[r].clr;
            current_ctx <= ctx;
            if (|eff) begin
                id             = ID_W'(top_bit(eff));
                model_mask[id] = 1'b1;
                // Dispatcher plus a full queue, later pushes are dropped
                if (exp_ids.size() < 1 + DEPTH) begin
                    exp_ids.push_back(id);
                    exp_ctxs.push_back(ctx);
                end else begin
                    exp_ovf = 1'b1;
                end
            end
            last = (r == NUM_ROWS - 1) ? 1'b1 : !rows[r + 1].burst;
            if (!rows[r].burst || last) begin
                @(posedge clk);
                int_req   <= '0;
                int_clear <= '0;
                // Grants come out in arrival order
                while (exp_ids.size() > 0) begin
                    serve_grant(rows[r].name, exp_ids.pop_front(), exp_ctxs.pop_front(),
                                rows[r].done ? 0 : HOLD_CYC);
                end
                wait_for_active(seen);
                assert (!seen) else report_mismatch(rows[r].name, "active", 64'(0), 64'(1));
                assert (overflow == exp_ovf)
                    else report_mismatch(rows[r].name, "overflow", 64'(exp_ovf), 64'(overflow));
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the interrupt controller testbench with Verilator and run it
# Exit status is zero only when the simulation finishes cleanly
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module icmu_tb -f verilog.f -Mdir obj_dir -o icmu_sim \
    && ./obj_dir/icmu_sim +verilator+error+limit+100 \
    || { echo "build or simulation returned an error"; exit 1; }

// File: source/grant_queue.sv
// Circular buffer of grants between the priority pipeline and the dispatcher
`timescale 1ns/1ps
`include "icmu_defines.svh"

module grant_queue import icmu_pkg::*; #(
    parameter int DEPTH = `ICMU_FIFO_DEPTH
) (
    input  logic   clk,
    input  logic   rst_n_buf,
    input  logic   push,
    input  grant_t push_grant,
    svc_if.queue   q
);

    // At least one pointer bit even for a single entry
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    grant_t             mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               do_write;
    logic               do_read;
    logic               overflow_q;

    // Wrap explicitly so a single-entry queue also works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign do_write = push && !full;
    assign do_read  = q.pop && !q.empty;

    // Storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= push_grant;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n_buf) begin
        if (!rst_n_buf) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Dropped push sticks until reset
    always_ff @(posedge clk or negedge rst_n_buf) begin
        if (!rst_n_buf) begin
            overflow_q <= 1'b0;
        end else if (push && full) begin
            overflow_q <= 1'b1;
        end
    end

    // Head is shown combinationally
    assign q.empty    = (count == '0);
    assign q.head     = mem[rd_ptr];
    assign q.overflow = overflow_q;

endmodule

// File: source/icmu_defines.svh
// Sizing macros for the interrupt controller, included by every RTL file that sizes a port
`ifndef ICMU_DEFINES_SVH
`define ICMU_DEFINES_SVH

// Number of interrupt request lines
`define ICMU_INT_WIDTH 8

// Width of the context word captured with each request
`define ICMU_CTX_WIDTH 32

// Source id width, log2 of the request width
`define ICMU_ID_WIDTH 3

// Grants held in the queue while the handler is busy
// Must be a power of two
`define ICMU_FIFO_DEPTH 4

// Grant record is id plus context
// Kept here so the bench can size its model without the package
`define ICMU_GRANT_WIDTH (`ICMU_ID_WIDTH + `ICMU_CTX_WIDTH)

`endif

// File: source/icmu_pkg.sv
// Shared types for the interrupt controller, imported by the queue, dispatcher and checker
`include "icmu_defines.svh"

package icmu_pkg;

    // One granted interrupt as it travels from pipeline to handler
    // Id sits in the upper bits, context below
    typedef struct packed {
        logic [`ICMU_ID_WIDTH-1:0]  id;
        logic [`ICMU_CTX_WIDTH-1:0] ctx;
    } grant_t;

    // Dispatcher FSM states
    // Idle waits on the queue
    // Active presents a grant until the handler strobes done
    typedef enum logic {
        SVC_IDLE   = 1'b0,
        SVC_ACTIVE = 1'b1
    } svc_state_t;

endpackage

// File: source/icmu_prio_pipe.sv
// Request sampler, masker and priority encoder that pushes one grant per accepted request
`timescale 1ns/1ps
`include "icmu_defines.svh"

module icmu_prio_pipe import icmu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_buf,
    input  logic [`ICMU_INT_WIDTH-1:0] int_req,
    input  logic [`ICMU_CTX_WIDTH-1:0] current_ctx,
    input  logic [`ICMU_INT_WIDTH-1:0] int_clear,
    output logic                       push,
    output grant_t                     push_grant
);

    // Stage 0, raw request and context
    logic                       s0_valid;
    logic [`ICMU_INT_WIDTH-1:0] s0_req;
    logic [`ICMU_CTX_WIDTH-1:0] s0_ctx;

    // Stage 1, request with already granted sources removed
    logic                       s1_valid;
    logic [`ICMU_INT_WIDTH-1:0] s1_req;
    logic [`ICMU_CTX_WIDTH-1:0] s1_ctx;

    // Stage 2, encoded grant
    logic                       s2_valid;
    grant_t                     s2_grant;

    // Sources granted and not yet cleared by software
    logic [`ICMU_INT_WIDTH-1:0] mask_q;
    logic [`ICMU_INT_WIDTH-1:0] mask_set;
    logic [`ICMU_INT_WIDTH-1:0] masked_req;
    logic [`ICMU_ID_WIDTH-1:0]  enc_id;

    // Highest set bit wins
    // Caller guarantees at least one bit is set
    function automatic logic [`ICMU_ID_WIDTH-1:0] highest_set(
        input logic [`ICMU_INT_WIDTH-1:0] vec
    );
        logic [`ICMU_ID_WIDTH-1:0] idx;
        idx = '0;
        for (int i = 0; i < `ICMU_INT_WIDTH; i++) begin
            if (vec[i]) begin
                idx = i[`ICMU_ID_WIDTH-1:0];
            end
        end
        return idx;
    endfunction

    // Mask read in stage 1 only sees pushes from four or more cycles back
    assign masked_req = s0_req & ~mask_q;
    assign enc_id     = highest_set(s1_req);

    // Valid bits and the push strobe
    // An empty masked set dies here and never reaches the queue
    always_ff @(posedge clk or negedge rst_n_buf) begin
        if (!rst_n_buf) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            push     <= 1'b0;
        end else begin
            s0_valid <= |int_req;
            s1_valid <= s0_valid && (|masked_req);
            s2_valid <= s1_valid;
            push     <= s2_valid;
        end
    end

    // Payload moves only with a valid item
    always_ff @(posedge clk) begin
        if (|int_req) begin
            s0_req <= int_req;
            s0_ctx <= current_ctx;
        end
        if (s0_valid) begin
            s1_req <= masked_req;
            s1_ctx <= s0_ctx;
        end
        if (s1_valid) begin
            s2_grant.id  <= enc_id;
            s2_grant.ctx <= s1_ctx;
        end
        if (s2_valid) begin
            push_grant <= s2_grant;
        end
    end

    // Decode of the source being pushed this cycle
    always_comb begin
        mask_set = '0;
        if (push) begin
            mask_set[push_grant.id] = 1'b1;
        end
    end

    // Clear strobe beats a set on the same edge
    always_ff @(posedge clk or negedge rst_n_buf) begin
        if (!rst_n_buf) begin
            mask_q <= '0;
        end else begin
            mask_q <= (mask_q | mask_set) & ~int_clear;
        end
    end

endmodule

// File: source/icmu_top.sv
// Interrupt controller top level, connects pipeline, grant queue and dispatcher behind plain ports
`timescale 1ns/1ps
`include "icmu_defines.svh"

module icmu_top import icmu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_buf,
    input  logic [`ICMU_INT_WIDTH-1:0] int_req,
    input  logic [`ICMU_CTX_WIDTH-1:0] current_ctx,
    input  logic [`ICMU_INT_WIDTH-1:0] int_clear,
    input  logic                       svc_done,
    output logic [`ICMU_INT_WIDTH-1:0] int_ack,
    output logic [`ICMU_ID_WIDTH-1:0]  int_id,
    output logic [`ICMU_CTX_WIDTH-1:0] saved_ctx,
    output logic                       active,
    output logic                       overflow
);

    // Pipeline to queue strobe and payload
    logic   push;
    grant_t push_grant;

    // Queue to dispatcher link
    svc_if svc_bus ();

    // Sample, mask and encode requests
    icmu_prio_pipe pipe0 (
        .clk         (clk),
        .rst_n_buf   (rst_n_buf),
        .int_req     (int_req),
        .current_ctx (current_ctx),
        .int_clear   (int_clear),
        .push        (push),
        .push_grant  (push_grant)
    );

    // Buffer grants while the handler is busy
    grant_queue #(
        .DEPTH (`ICMU_FIFO_DEPTH)
    ) queue0 (
        .clk        (clk),
        .rst_n_buf  (rst_n_buf),
        .push       (push),
        .push_grant (push_grant),
        .q          (svc_bus.queue)
    );

    // Present one grant at a time to the handler
    svc_dispatch disp0 (
        .clk       (clk),
        .rst_n_buf (rst_n_buf),
        .svc_done  (svc_done),
        .d         (svc_bus.dispatcher),
        .int_ack   (int_ack),
        .int_id    (int_id),
        .saved_ctx (saved_ctx),
        .active    (active)
    );

    // Sticky overflow comes straight from the queue
    assign overflow = svc_bus.overflow;

endmodule

// File: source/svc_dispatch.sv
// Service FSM that takes one queued grant and holds it on the handler outputs until done
`timescale 1ns/1ps
`include "icmu_defines.svh"

module svc_dispatch import icmu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_buf,
    input  logic                       svc_done,
    svc_if.dispatcher                  d,
    output logic [`ICMU_INT_WIDTH-1:0] int_ack,
    output logic [`ICMU_ID_WIDTH-1:0]  int_id,
    output logic [`ICMU_CTX_WIDTH-1:0] saved_ctx,
    output logic                       active
);

    svc_state_t                 state;
    logic [`ICMU_ID_WIDTH-1:0]  id_q;
    logic [`ICMU_CTX_WIDTH-1:0] ctx_q;

    // Pop in the same cycle the FSM leaves idle
    // State change makes it a single-cycle strobe
    assign d.pop = (state == SVC_IDLE) && !d.empty;

    // Queue is ignored while a grant is in service
    // Done while idle falls through the case and does nothing
    always_ff @(posedge clk or negedge rst_n_buf) begin
        if (!rst_n_buf) begin
            state <= SVC_IDLE;
            id_q  <= '0;
            ctx_q <= '0;
        end else begin
            case (state)
                SVC_IDLE: begin
                    if (!d.empty) begin
                        state <= SVC_ACTIVE;
                        id_q  <= d.head.id;
                        ctx_q <= d.head.ctx;
                    end
                end
                SVC_ACTIVE: begin
                    if (svc_done) begin
                        state <= SVC_IDLE;
                        id_q  <= '0;
                        ctx_q <= '0;
                    end
                end
                default: begin
                    state <= SVC_IDLE;
                end
            endcase
        end
    end

    assign active    = (state == SVC_ACTIVE);
    assign int_id    = id_q;
    assign saved_ctx = ctx_q;

    // One-hot acknowledge of the source in service
    // All zero when idle
    always_comb begin
        int_ack = '0;
        if (active) begin
            int_ack[id_q] = 1'b1;
        end
    end

endmodule

// File: source/svc_if.sv
// Grant queue to service dispatcher link, one instance per controller in the top level
`timescale 1ns/1ps

interface svc_if import icmu_pkg::*; ();

    // Queue has nothing to hand out
    logic   empty;

    // One-cycle strobe from the dispatcher, head advances on the next edge
    logic   pop;

    // Oldest grant, valid whenever empty is low
    grant_t head;

    // Sticky flag, a push was dropped because the queue was full
    // Only the top level reads it
    logic   overflow;

    // Buffer side
    modport queue (
        input  pop,
        output empty,
        output head,
        output overflow
    );

    // Consumer side
    modport dispatcher (
        input  empty,
        input  head,
        output pop
    );

endinterface

// File: verilog.f
+incdir+source
source/icmu_pkg.sv
source/svc_if.sv
source/icmu_prio_pipe.sv
source/grant_queue.sv
source/svc_dispatch.sv
source/icmu_top.sv
bench/icmu_chk.sv
bench/icmu_tb.sv
